//--- common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // Address split
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;

    localparam int BANKS    = 4;
    localparam int NUM_SETS = 2 ** INDEX_W;

    typedef logic [31:0]          addr_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [INDEX_W-1:0]   index_t;
    // Upper two bits pick the bank
    typedef logic [OFFSET_W-1:0]  offset_t;
    typedef logic [1:0]           bank_sel_t;
    typedef logic [31:0]          word_t;
    typedef logic [3:0]           strb_t;
    // Bank 0 sits in the low word
    typedef logic [BANKS*32-1:0]  line_t;
    typedef logic                 way_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } main_state_t;

    typedef enum logic {
        S_IDLE,
        S_WRITE
    } store_state_t;

endpackage

`default_nettype wire

//--- dcache/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      valid,
    input  wire                      op,
    input  wire dcache_pkg::tag_t    tag,
    input  wire dcache_pkg::index_t  index,
    input  wire dcache_pkg::offset_t offset,
    input  wire dcache_pkg::strb_t   wstrb,
    input  wire dcache_pkg::word_t   wdata,
    output logic                     addr_ok,
    output logic                     data_ok,
    output dcache_pkg::word_t        rdata,
    output logic                     rd_req,
    output dcache_pkg::addr_t        rd_addr,
    input  wire                      rd_rdy,
    input  wire                      ret_valid,
    input  wire dcache_pkg::line_t   ret_data,
    output logic                     wr_req,
    output dcache_pkg::addr_t        wr_addr,
    output dcache_pkg::line_t        wr_data,
    input  wire                      wr_rdy,
    input  wire dcache_pkg::tag_t    way0_tag,
    input  wire dcache_pkg::tag_t    way1_tag,
    input  wire                      way0_valid,
    input  wire                      way1_valid,
    input  wire dcache_pkg::way_t    recent,
    input  wire                      victim_dirty,
    input  wire dcache_pkg::line_t   way0_line,
    input  wire dcache_pkg::line_t   way1_line,
    input  wire                      busy,
    output logic                     rd_en,
    output dcache_pkg::index_t       rd_index,
    output logic                     fill_en,
    output dcache_pkg::way_t         fill_way,
    output dcache_pkg::index_t       fill_index,
    output dcache_pkg::tag_t         fill_tag,
    output logic                     fill_dirty,
    output dcache_pkg::line_t        fill_line,
    output logic                     touch_en,
    output dcache_pkg::way_t         touch_way,
    output dcache_pkg::index_t       touch_index,
    output logic                     capture,
    output dcache_pkg::way_t         sb_way,
    output dcache_pkg::index_t       sb_index,
    output dcache_pkg::offset_t      sb_offset,
    output dcache_pkg::strb_t        sb_strb,
    output dcache_pkg::word_t        sb_data
);

    dcache_pkg::main_state_t state;
    dcache_pkg::main_state_t next_state;

    logic                  rb_op;
    dcache_pkg::tag_t      rb_tag;
    dcache_pkg::index_t    rb_index;
    dcache_pkg::offset_t   rb_offset;
    dcache_pkg::strb_t     rb_wstrb;
    dcache_pkg::word_t     rb_wdata;
    dcache_pkg::bank_sel_t rb_bank;

    logic                  way0_hit;
    logic                  way1_hit;
    logic                  cache_hit;
    logic                  in_lookup;
    logic                  accept;
    dcache_pkg::way_t      victim;
    dcache_pkg::line_t     merged_line;

    // Miss register
    dcache_pkg::way_t      vict_way_r;
    dcache_pkg::tag_t      vict_tag_r;
    logic                  vict_valid_r;
    logic                  vict_dirty_r;
    dcache_pkg::line_t     vict_line_r;

    assign in_lookup = state == dcache_pkg::LOOKUP;
    assign accept    = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (accept) begin
            rb_op     <= op;
            rb_tag    <= tag;
            rb_index  <= index;
            rb_offset <= offset;
            rb_wstrb  <= wstrb;
            rb_wdata  <= wdata;
        end
    end

    assign rb_bank   = rb_offset[3:2];
    assign way0_hit  = way0_valid && way0_tag == rb_tag;
    assign way1_hit  = way1_valid && way1_tag == rb_tag;
    assign cache_hit = way0_hit || way1_hit;

    // Invalid way first, else the one not used last
    assign victim = !way0_valid ? 1'b0 : (!way1_valid ? 1'b1 : ~recent);

    always_ff @(posedge clk) begin
        if (in_lookup && !cache_hit) begin
            vict_way_r   <= victim;
            vict_tag_r   <= victim ? way1_tag : way0_tag;
            vict_valid_r <= victim ? way1_valid : way0_valid;
            vict_dirty_r <= victim_dirty;
            vict_line_r  <= victim ? way1_line : way0_line;
        end
    end

    // Pending store bytes laid over the returned line
    always_comb begin
        merged_line = ret_data;
        for (int i = 0; i < 4; i++) begin
            if (rb_op && rb_wstrb[i])
                merged_line[rb_bank*32 + i*8 +: 8] = rb_wdata[i*8 +: 8];
        end
    end

    assign addr_ok = valid && !busy &&
                     (state == dcache_pkg::IDLE || (in_lookup && cache_hit && !rb_op));
    assign data_ok = (in_lookup && cache_hit) || (state == dcache_pkg::REFILL && ret_valid);
    assign rdata   = !in_lookup ? merged_line[rb_bank*32 +: 32] :
                     (way1_hit ? way1_line[rb_bank*32 +: 32] : way0_line[rb_bank*32 +: 32]);

    assign rd_en    = accept;
    assign rd_index = index;

    assign fill_en    = state == dcache_pkg::REFILL && ret_valid;
    assign fill_way   = in_lookup ? victim : vict_way_r;
    assign fill_index = rb_index;
    assign fill_tag   = rb_tag;
    assign fill_dirty = rb_op;
    assign fill_line  = merged_line;

    assign touch_en    = (in_lookup && cache_hit) || fill_en;
    assign touch_way   = in_lookup ? way1_hit : vict_way_r;
    assign touch_index = rb_index;

    assign capture   = in_lookup && cache_hit && rb_op;
    assign sb_way    = way1_hit;
    assign sb_index  = rb_index;
    assign sb_offset = rb_offset;
    assign sb_strb   = rb_wstrb;
    assign sb_data   = rb_wdata;

    assign wr_req  = state == dcache_pkg::MISS && vict_valid_r && vict_dirty_r;
    assign wr_addr = {vict_tag_r, rb_index, {dcache_pkg::OFFSET_W{1'b0}}};
    assign wr_data = vict_line_r;
    assign rd_req  = state == dcache_pkg::REPLACE;
    assign rd_addr = {rb_tag, rb_index, {dcache_pkg::OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::IDLE: begin
                if (accept)
                    next_state = dcache_pkg::LOOKUP;
            end
            dcache_pkg::LOOKUP: begin
                if (!cache_hit)
                    next_state = dcache_pkg::MISS;
                else if (!accept)
                    next_state = dcache_pkg::IDLE;
            end
            dcache_pkg::MISS: begin
                // Clean or empty victim skips the write-back
                if (!wr_req || wr_rdy)
                    next_state = dcache_pkg::REPLACE;
            end
            dcache_pkg::REPLACE: begin
                if (rd_rdy)
                    next_state = dcache_pkg::REFILL;
            end
            dcache_pkg::REFILL: begin
                if (ret_valid)
                    next_state = dcache_pkg::IDLE;
            end
            default: next_state = dcache_pkg::IDLE;
        endcase
    end

    a_one_mem_req: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req));

    a_no_data_ok_idle_miss: assert property (@(posedge clk) disable iff (!resetn)
        (state == dcache_pkg::IDLE || state == dcache_pkg::MISS) |-> !data_ok);

endmodule

`default_nettype wire

//--- dcache/data_store.sv
`timescale 1ns/1ps
`default_nettype none

module data_store (
    input  wire                        clk,
    input  wire                        rd_en,
    input  wire dcache_pkg::index_t    rd_index,
    input  wire                        fill_en,
    input  wire dcache_pkg::way_t      fill_way,
    input  wire dcache_pkg::index_t    fill_index,
    input  wire dcache_pkg::line_t     fill_line,
    input  wire                        st_en,
    input  wire dcache_pkg::way_t      st_way,
    input  wire dcache_pkg::index_t    st_index,
    input  wire dcache_pkg::bank_sel_t st_bank,
    input  wire dcache_pkg::strb_t     st_strb,
    input  wire dcache_pkg::word_t     st_data,
    output dcache_pkg::line_t          way0_line,
    output dcache_pkg::line_t          way1_line
);

    wire dcache_pkg::line_t lines [2];

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < dcache_pkg::BANKS; b++) begin : g_bank
            dcache_pkg::word_t  ram [dcache_pkg::NUM_SETS];
            dcache_pkg::word_t  dout;
            dcache_pkg::index_t addr;
            dcache_pkg::strb_t  we;
            dcache_pkg::word_t  din;
            logic               st_sel;
            logic               fill_sel;

            assign st_sel   = st_en && st_way == w && st_bank == b;
            assign fill_sel = fill_en && fill_way == w;
            // Store write wins over fill, fill over read
            assign addr = st_sel ? st_index : (fill_sel ? fill_index : rd_index);
            assign we   = st_sel ? st_strb : {4{fill_sel}};
            assign din  = st_sel ? st_data : fill_line[b*32 +: 32];

            always_ff @(posedge clk) begin
                if (st_sel || fill_sel) begin
                    for (int i = 0; i < 4; i++) begin
                        if (we[i])
                            ram[addr][i*8 +: 8] <= din[i*8 +: 8];
                    end
                end else if (rd_en) begin
                    dout <= ram[addr];
                end
            end

            assign lines[w][b*32 +: 32] = dout;
        end
    end

    assign way0_line = lines[0];
    assign way1_line = lines[1];

    // Store buffer must hold off new lookups while it writes
    a_no_read_during_store: assert property (@(posedge clk) !(rd_en && st_en));

endmodule

`default_nettype wire

//--- dcache/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    valid,
    input  wire                    op,
    input  wire dcache_pkg::tag_t    tag,
    input  wire dcache_pkg::index_t  index,
    input  wire dcache_pkg::offset_t offset,
    input  wire dcache_pkg::strb_t   wstrb,
    input  wire dcache_pkg::word_t   wdata,
    output logic                   addr_ok,
    output logic                   data_ok,
    output dcache_pkg::word_t      rdata,
    output logic                   rd_req,
    output dcache_pkg::addr_t      rd_addr,
    input  wire                    rd_rdy,
    input  wire                    ret_valid,
    input  wire dcache_pkg::line_t   ret_data,
    output logic                   wr_req,
    output dcache_pkg::addr_t      wr_addr,
    output dcache_pkg::line_t      wr_data,
    input  wire                    wr_rdy
);

    logic                   rd_en;
    dcache_pkg::index_t     rd_index;
    logic                   fill_en;
    dcache_pkg::way_t       fill_way;
    dcache_pkg::index_t     fill_index;
    dcache_pkg::tag_t       fill_tag;
    logic                   fill_dirty;
    dcache_pkg::line_t      fill_line;
    logic                   touch_en;
    dcache_pkg::way_t       touch_way;
    dcache_pkg::index_t     touch_index;
    dcache_pkg::tag_t       way0_tag;
    dcache_pkg::tag_t       way1_tag;
    logic                   way0_valid;
    logic                   way1_valid;
    dcache_pkg::way_t       recent;
    logic                   victim_dirty;
    dcache_pkg::line_t      way0_line;
    dcache_pkg::line_t      way1_line;

    // Store hit path
    logic                   busy;
    logic                   capture;
    dcache_pkg::way_t       sb_way;
    dcache_pkg::index_t     sb_index;
    dcache_pkg::offset_t    sb_offset;
    dcache_pkg::strb_t      sb_strb;
    dcache_pkg::word_t      sb_data;
    logic                   st_en;
    dcache_pkg::way_t       st_way;
    dcache_pkg::index_t     st_index;
    dcache_pkg::bank_sel_t  st_bank;
    dcache_pkg::strb_t      st_strb;
    dcache_pkg::word_t      st_data;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .op           (op),
        .tag          (tag),
        .index        (index),
        .offset       (offset),
        .wstrb        (wstrb),
        .wdata        (wdata),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_data     (ret_data),
        .wr_req       (wr_req),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .wr_rdy       (wr_rdy),
        .way0_tag     (way0_tag),
        .way1_tag     (way1_tag),
        .way0_valid   (way0_valid),
        .way1_valid   (way1_valid),
        .recent       (recent),
        .victim_dirty (victim_dirty),
        .way0_line    (way0_line),
        .way1_line    (way1_line),
        .busy         (busy),
        .rd_en        (rd_en),
        .rd_index     (rd_index),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_dirty   (fill_dirty),
        .fill_line    (fill_line),
        .touch_en     (touch_en),
        .touch_way    (touch_way),
        .touch_index  (touch_index),
        .capture      (capture),
        .sb_way       (sb_way),
        .sb_index     (sb_index),
        .sb_offset    (sb_offset),
        .sb_strb      (sb_strb),
        .sb_data      (sb_data)
    );

    tag_store u_tags (
        .clk             (clk),
        .resetn          (resetn),
        .rd_en           (rd_en),
        .rd_index        (rd_index),
        .fill_en         (fill_en),
        .fill_way        (fill_way),
        .fill_index      (fill_index),
        .fill_tag        (fill_tag),
        .fill_dirty      (fill_dirty),
        .dirty_set_en    (st_en),
        .dirty_set_way   (st_way),
        .dirty_set_index (st_index),
        .touch_en        (touch_en),
        .touch_way       (touch_way),
        .touch_index     (touch_index),
        .way0_tag        (way0_tag),
        .way1_tag        (way1_tag),
        .way0_valid      (way0_valid),
        .way1_valid      (way1_valid),
        .recent          (recent),
        .victim_dirty    (victim_dirty)
    );

    data_store u_data (
        .clk        (clk),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_index (fill_index),
        .fill_line  (fill_line),
        .st_en      (st_en),
        .st_way     (st_way),
        .st_index   (st_index),
        .st_bank    (st_bank),
        .st_strb    (st_strb),
        .st_data    (st_data),
        .way0_line  (way0_line),
        .way1_line  (way1_line)
    );

    store_buffer u_sbuf (
        .clk      (clk),
        .resetn   (resetn),
        .capture  (capture),
        .hit_way  (sb_way),
        .index    (sb_index),
        .offset   (sb_offset),
        .strb     (sb_strb),
        .data     (sb_data),
        .busy     (busy),
        .st_en    (st_en),
        .st_way   (st_way),
        .st_index (st_index),
        .st_bank  (st_bank),
        .st_strb  (st_strb),
        .st_data  (st_data)
    );

endmodule

`default_nettype wire

//--- dcache/store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module store_buffer (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         capture,
    input  wire dcache_pkg::way_t       hit_way,
    input  wire dcache_pkg::index_t     index,
    input  wire dcache_pkg::offset_t    offset,
    input  wire dcache_pkg::strb_t      strb,
    input  wire dcache_pkg::word_t      data,
    output logic                        busy,
    output logic                        st_en,
    output dcache_pkg::way_t            st_way,
    output dcache_pkg::index_t          st_index,
    output dcache_pkg::bank_sel_t       st_bank,
    output dcache_pkg::strb_t           st_strb,
    output dcache_pkg::word_t           st_data
);

    dcache_pkg::store_state_t state;
    dcache_pkg::bank_sel_t    bank_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= dcache_pkg::S_IDLE;
        end else if (capture) begin
            state <= dcache_pkg::S_WRITE;
        end else begin
            state <= dcache_pkg::S_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            st_way   <= hit_way;
            st_index <= index;
            bank_q   <= offset[3:2];
            st_strb  <= strb;
            st_data  <= data;
        end
    end

    // One bank write per captured store
    assign st_en   = state == dcache_pkg::S_WRITE;
    assign busy    = st_en;
    assign st_bank = bank_q;

endmodule

`default_nettype wire

//--- dcache/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     rd_en,
    input  wire dcache_pkg::index_t rd_index,
    input  wire                     fill_en,
    input  wire dcache_pkg::way_t   fill_way,
    input  wire dcache_pkg::index_t fill_index,
    input  wire dcache_pkg::tag_t   fill_tag,
    input  wire                     fill_dirty,
    input  wire                     dirty_set_en,
    input  wire dcache_pkg::way_t   dirty_set_way,
    input  wire dcache_pkg::index_t dirty_set_index,
    input  wire                     touch_en,
    input  wire dcache_pkg::way_t   touch_way,
    input  wire dcache_pkg::index_t touch_index,
    output dcache_pkg::tag_t        way0_tag,
    output dcache_pkg::tag_t        way1_tag,
    output logic                    way0_valid,
    output logic                    way1_valid,
    output dcache_pkg::way_t        recent,
    output logic                    victim_dirty
);

    dcache_pkg::tag_t                  tag_ram [2][dcache_pkg::NUM_SETS];
    logic [dcache_pkg::NUM_SETS-1:0]   valid_q [2];
    logic [dcache_pkg::NUM_SETS-1:0]   dirty_q [2];
    // Way most recently hit or refilled, per set
    logic [dcache_pkg::NUM_SETS-1:0]   recent_q;

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_ram[fill_way][fill_index] <= fill_tag;
        end
        if (rd_en) begin
            way0_tag <= tag_ram[0][rd_index];
            way1_tag <= tag_ram[1][rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            way0_valid <= 1'b0;
            way1_valid <= 1'b0;
        end else begin
            if (fill_en) begin
                valid_q[fill_way][fill_index] <= 1'b1;
            end
            if (rd_en) begin
                way0_valid <= valid_q[0][rd_index];
                way1_valid <= valid_q[1][rd_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
            recent_q   <= '0;
        end else begin
            if (fill_en) begin
                dirty_q[fill_way][fill_index] <= fill_dirty;
            end
            if (dirty_set_en) begin
                dirty_q[dirty_set_way][dirty_set_index] <= 1'b1;
            end
            if (touch_en) begin
                recent_q[touch_index] <= touch_way;
            end
        end
    end

    // Live read, so back to back lookups see the latest update
    assign recent       = recent_q[fill_index];
    assign victim_dirty = dirty_q[fill_way][fill_index];

    a_fill_vs_dirty_set: assert property (@(posedge clk) disable iff (!resetn)
        !(fill_en && dirty_set_en && fill_index == dirty_set_index));

endmodule

`default_nettype wire

//--- project.f
+incdir+verification
common/dcache_pkg.sv
dcache/tag_store.sv
dcache/data_store.sv
dcache/store_buffer.sv
dcache/cache_ctrl.sv
dcache/dcache_top.sv
verification/tb_dcache.sv

//--- verification/tb_cache_model.svh
`ifndef TB_CACHE_MODEL_SVH
`define TB_CACHE_MODEL_SVH

// CPU view of every line touched so far, keyed by line address
dcache_pkg::line_t img [dcache_pkg::addr_t];

// Mirror of the cache directory
dcache_pkg::tag_t  m_tag    [2][dcache_pkg::NUM_SETS];
logic              m_valid  [2][dcache_pkg::NUM_SETS];
logic              m_dirty  [2][dcache_pkg::NUM_SETS];
logic              m_recent [dcache_pkg::NUM_SETS];

// Power-on memory contents, mixed from every address bit
function automatic dcache_pkg::line_t init_line(input dcache_pkg::addr_t line_addr);
    dcache_pkg::line_t l;
    for (int b = 0; b < dcache_pkg::BANKS; b++) begin
        l[b*32 +: 32] = ((line_addr + b * 4) * 32'h9e3779b1) ^ 32'h5bd1e995;
    end
    return l;
endfunction

function automatic dcache_pkg::line_t image_line(input dcache_pkg::addr_t line_addr);
    return img.exists(line_addr) ? img[line_addr] : init_line(line_addr);
endfunction

task automatic model_reset;
    for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
        m_valid[0][s] = 1'b0;
        m_valid[1][s] = 1'b0;
        m_dirty[0][s] = 1'b0;
        m_dirty[1][s] = 1'b0;
        m_recent[s]   = 1'b0;
    end
endtask

task automatic model_access(input logic is_store, input dcache_pkg::tag_t t,
        input dcache_pkg::index_t i, input dcache_pkg::offset_t o,
        input dcache_pkg::strb_t strb, input dcache_pkg::word_t d,
        output dcache_pkg::word_t exp_data, output logic miss, output logic wb,
        output dcache_pkg::addr_t wb_addr, output dcache_pkg::line_t wb_line);
    dcache_pkg::addr_t line_addr;
    dcache_pkg::line_t l;
    logic              hit0;
    logic              hit1;
    logic              way;
    line_addr = {t, i, 4'h0};
    hit0 = m_valid[0][i] && m_tag[0][i] == t;
    hit1 = m_valid[1][i] && m_tag[1][i] == t;
    miss = !(hit0 || hit1);
    wb = 1'b0;
    wb_addr = '0;
    wb_line = '0;
    if (miss) begin
        // Invalid way first, else the way not used last
        way = !m_valid[0][i] ? 1'b0 : (!m_valid[1][i] ? 1'b1 : !m_recent[i]);
        if (m_valid[way][i] && m_dirty[way][i]) begin
            wb = 1'b1;
            wb_addr = {m_tag[way][i], i, 4'h0};
            wb_line = image_line(wb_addr);
        end
        m_tag[way][i] = t;
        m_valid[way][i] = 1'b1;
        m_dirty[way][i] = is_store;
    end else begin
        way = hit1;
        if (is_store)
            m_dirty[way][i] = 1'b1;
    end
    m_recent[i] = way;
    l = image_line(line_addr);
    for (int b = 0; b < 4; b++) begin
        if (is_store && strb[b])
            l[o[3:2]*32 + b*8 +: 8] = d[b*8 +: 8];
    end
    img[line_addr] = l;
    exp_data = l[o[3:2]*32 +: 32];
endtask

`endif

//--- verification/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    localparam int NUM_REQ = 400;
    localparam int TIMEOUT = NUM_REQ * 20;

    logic clk = 1'b0;
    logic resetn;
    logic valid;
    logic op;
    dcache_pkg::tag_t    tag;
    dcache_pkg::index_t  index;
    dcache_pkg::offset_t offset;
    dcache_pkg::strb_t   wstrb;
    dcache_pkg::word_t   wdata;
    logic                addr_ok;
    logic                data_ok;
    dcache_pkg::word_t   rdata;
    logic                rd_req;
    dcache_pkg::addr_t   rd_addr;
    logic                rd_rdy;
    logic                ret_valid;
    dcache_pkg::line_t   ret_data;
    logic                wr_req;
    dcache_pkg::addr_t   wr_addr;
    dcache_pkg::line_t   wr_data;
    logic                wr_rdy;

    integer seed = 32'ha0498ea2;
    int errors = 0;
    int cycles = 0;
    int issued = 0;
    int accepted = 0;
    int completed = 0;

    // Memory side
    dcache_pkg::line_t backing [dcache_pkg::addr_t];
    int rd_wait = 0;
    int wr_wait = 0;
    int ret_wait = 0;
    logic ret_pending = 1'b0;
    dcache_pkg::line_t ret_line;

    // Values seen at the falling edge, used by the drivers
    logic s_accept = 1'b0;
    logic s_rd_req = 1'b0;
    logic s_rd_rdy = 1'b0;
    logic s_wr_req = 1'b0;
    logic s_wr_rdy = 1'b0;
    dcache_pkg::addr_t s_rd_addr;

    // Expectations
    dcache_pkg::word_t exp_q [$];
    logic              op_q [$];
    logic              exp_op;
    dcache_pkg::word_t exp_word;
    logic              exp_rd = 1'b0;
    dcache_pkg::addr_t exp_rd_addr;
    logic              exp_wb = 1'b0;
    dcache_pkg::addr_t exp_wb_addr;
    dcache_pkg::line_t exp_wb_line;
    logic              miss;
    logic              hold_rd = 1'b0;
    logic              hold_wr = 1'b0;
    dcache_pkg::addr_t hold_rd_addr;
    dcache_pkg::addr_t hold_wr_addr;
    dcache_pkg::line_t hold_wr_data;
    // Lookup cycle and store write cycle as the model sees them
    logic              exp_addr_ok;
    logic              looking_up = 1'b0;
    logic              sb_busy = 1'b0;

    `include "tb_cache_model.svh"

    dcache_top DUT (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .tag       (tag),
        .index     (index),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    always #2 clk = ~clk;

    function automatic dcache_pkg::line_t backing_read(input dcache_pkg::addr_t line_addr);
        return backing.exists(line_addr) ? backing[line_addr] : init_line(line_addr);
    endfunction

    task drive_cpu;
        logic [31:0] r;
        if (!valid || s_accept) begin
            r = $random(seed);
            // Two sets, four tags each, with an idle cycle now and then
            if (issued < NUM_REQ && r[15:14] != 2'b00) begin
                valid  <= 1'b1;
                op     <= r[0];
                index  <= r[1] ? 8'ha7 : 8'h3c;
                tag    <= 20'h4b1c0 + r[3:2];
                offset <= r[7:4];
                wstrb  <= r[11:8];
                wdata  <= $random(seed);
                issued = issued + 1;
            end else begin
                valid <= 1'b0;
            end
        end
    endtask

    task drive_memory;
        rd_rdy    <= 1'b0;
        wr_rdy    <= 1'b0;
        ret_valid <= 1'b0;
        if (s_rd_req && !s_rd_rdy) begin
            if (rd_wait == 0)
                rd_rdy <= 1'b1;
            else
                rd_wait <= rd_wait - 1;
        end
        if (s_rd_req && s_rd_rdy) begin
            rd_wait     <= $unsigned($random(seed)) % 5;
            ret_wait    <= $unsigned($random(seed)) % 5;
            ret_pending <= 1'b1;
            ret_line    <= backing_read(s_rd_addr);
        end
        if (s_wr_req && !s_wr_rdy) begin
            if (wr_wait == 0)
                wr_rdy <= 1'b1;
            else
                wr_wait <= wr_wait - 1;
        end
        if (s_wr_req && s_wr_rdy)
            wr_wait <= $unsigned($random(seed)) % 5;
        if (ret_pending) begin
            if (ret_wait == 0) begin
                ret_valid   <= 1'b1;
                ret_data    <= ret_line;
                ret_pending <= 1'b0;
            end else begin
                ret_wait <= ret_wait - 1;
            end
        end
    endtask

    always @(posedge clk) begin
        if (resetn) begin
            drive_cpu();
            drive_memory();
        end
    end

    always @(negedge clk) begin
        if (resetn) begin
            cycles++;
            // Ready when idle, or in the lookup of a load hit, unless a store write runs
            exp_addr_ok = valid && !sb_busy &&
                          (exp_q.size() == 0 || (looking_up && !miss && !op_q[0]));
            assert (addr_ok == exp_addr_ok) else begin
                errors++;
                $display("FAIL addr_ok: got %h, expected %h", addr_ok, exp_addr_ok);
            end
            sb_busy = looking_up && !miss && op_q.size() > 0 && op_q[0];
            if (accepted == 0) begin
                assert (!data_ok && !rd_req && !wr_req) else begin
                    errors++;
                    $display("Cache output activity seen before the first accepted request");
                end
            end
            if (data_ok) begin
                assert (exp_q.size() > 0 && !exp_rd) else begin
                    errors++;
                    $display("data_ok without a pending request or before its line was read");
                end
                if (exp_q.size() > 0) begin
                    exp_op = op_q.pop_front();
                    exp_word = exp_q.pop_front();
                    if (!exp_op) begin
                        assert (rdata == exp_word) else begin
                            errors++;
                            $display("FAIL rdata: got %h, expected %h", rdata, exp_word);
                        end
                    end
                end
                completed++;
            end
            if (wr_req) begin
                assert (exp_wb) else begin
                    errors++;
                    $display("Write-back issued although the victim needs none");
                end
                if (wr_rdy) begin
                    assert (wr_addr == exp_wb_addr) else begin
                        errors++;
                        $display("FAIL wr_addr: got %h, expected %h", wr_addr, exp_wb_addr);
                    end
                    assert (wr_data == exp_wb_line) else begin
                        errors++;
                        $display("FAIL wr_data: got %h, expected %h", wr_data, exp_wb_line);
                    end
                    backing[wr_addr] = wr_data;
                    exp_wb = 1'b0;
                end
            end
            if (hold_wr) begin
                assert (wr_req && wr_addr == hold_wr_addr && wr_data == hold_wr_data) else begin
                    errors++;
                    $display("Write request dropped or changed before wr_rdy");
                end
            end
            if (rd_req) begin
                assert (exp_rd && !exp_wb) else begin
                    errors++;
                    $display("Line read without a miss, or ahead of the victim write-back");
                end
                assert (rd_addr == exp_rd_addr) else begin
                    errors++;
                    $display("FAIL rd_addr: got %h, expected %h", rd_addr, exp_rd_addr);
                end
                if (rd_rdy)
                    exp_rd = 1'b0;
            end
            if (hold_rd) begin
                assert (rd_req && rd_addr == hold_rd_addr) else begin
                    errors++;
                    $display("Read request dropped or changed before rd_rdy");
                end
            end
            hold_wr = wr_req && !wr_rdy;
            hold_wr_addr = wr_addr;
            hold_wr_data = wr_data;
            hold_rd = rd_req && !rd_rdy;
            hold_rd_addr = rd_addr;
            if (valid && addr_ok) begin
                model_access(op, tag, index, offset, wstrb, wdata, exp_word, miss,
                             exp_wb, exp_wb_addr, exp_wb_line);
                exp_q.push_back(exp_word);
                op_q.push_back(op);
                exp_rd = miss;
                exp_rd_addr = {tag, index, 4'h0};
                accepted++;
                assert (exp_q.size() <= 1) else begin
                    errors++;
                    $display("Request accepted before the previous one completed");
                end
            end
            looking_up = valid && addr_ok;
        end
        s_accept  <= valid && addr_ok;
        s_rd_req  <= rd_req;
        s_rd_rdy  <= rd_rdy;
        s_wr_req  <= wr_req;
        s_wr_rdy  <= wr_rdy;
        s_rd_addr <= rd_addr;
    end

    initial begin
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = 1'b0;
        tag       = '0;
        index     = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        model_reset();
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        while (completed < NUM_REQ && cycles < TIMEOUT)
            @(posedge clk);
        if (completed < NUM_REQ) begin
            errors++;
            $display("Timeout after %0d cycles with %0d of %0d requests completed",
                     cycles, completed, NUM_REQ);
        end
        $display("requests %0d, completions %0d, errors %0d", accepted, completed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
